// ==== rtl/dc_video_pkg.sv ====
package dc_video_pkg;

    // pixel column or line number
    typedef logic [11:0] coord_t;

    // address into the line ring
    typedef logic [11:0] ram_addr_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic      wren;
        ram_addr_t addr;
        rgb_t      data;
    } ram_write_t;

    // slot of the line in the ring times the line length, plus column
    function automatic ram_addr_t ring_addr(coord_t line, coord_t col,
                                            int line_width, int ring_lines);
        return ram_addr_t'(line % coord_t'(ring_lines)) * ram_addr_t'(line_width)
               + ram_addr_t'(col);
    endfunction

endpackage

// ==== rtl/dc_video_capture.sv ====
module dc_video_capture (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 _hsync,
    input  logic                 _vsync,
    input  logic [11:0]          data,
    output logic                 pixel_valid,
    output dc_video_pkg::rgb_t   pixel,
    output dc_video_pkg::coord_t x,
    output dc_video_pkg::coord_t y
);
    import dc_video_pkg::*;

    logic        hsync_q;
    logic        vsync_q;
    logic        hsync_rise;
    logic        vsync_rise;
    logic        second_half;
    logic [11:0] first_half;
    coord_t      col_count;
    coord_t      line_next;

    // rising edge ends the active-low pulse
    assign hsync_rise = _hsync & ~hsync_q;
    assign vsync_rise = _vsync & ~vsync_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            hsync_q <= 1'b1;
            vsync_q <= 1'b1;
        end else begin
            hsync_q <= _hsync;
            vsync_q <= _vsync;
        end
    end

    // half phase restarts on the first pixel of a line
    always_ff @(posedge clock) begin
        if (reset) begin
            second_half <= 1'b0;
            pixel_valid <= 1'b0;
            col_count   <= '0;
        end else begin
            pixel_valid <= 1'b0;
            if (hsync_rise) begin
                second_half <= 1'b1;
                col_count   <= '0;
            end else if (second_half) begin
                second_half <= 1'b0;
                pixel_valid <= 1'b1;
                col_count   <= col_count + 1'b1;
            end else begin
                second_half <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (hsync_rise || !second_half) begin
            first_half <= data;
        end
        if (second_half && !hsync_rise) begin
            pixel <= '{red:   first_half[11:4],
                       green: {first_half[3:0], data[11:8]},
                       blue:  data[7:0]};
            x     <= col_count;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_next <= '0;
            y         <= '0;
        end else if (hsync_rise) begin
            // vsync rise in the same cycle makes this line number zero
            y         <= vsync_rise ? coord_t'(0) : line_next;
            line_next <= vsync_rise ? coord_t'(1) : line_next + 1'b1;
        end else if (vsync_rise) begin
            line_next <= '0;
        end
    end

endmodule

// ==== rtl/line_writer.sv ====
module line_writer #(
    parameter int ACTIVE_WIDTH  = 16,
    parameter int ACTIVE_HEIGHT = 8,
    parameter int BUFFER_LINES  = 4,
    parameter int START_LINE    = 2
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     pixel_valid,
    input  dc_video_pkg::rgb_t       pixel,
    input  dc_video_pkg::coord_t     x,
    input  dc_video_pkg::coord_t     y,
    output dc_video_pkg::ram_write_t wr,
    output logic                     frame_start
);
    import dc_video_pkg::*;

    logic      in_window;
    logic      wren_q;
    ram_addr_t addr_q;
    rgb_t      data_q;

    assign in_window = pixel_valid && x < coord_t'(ACTIVE_WIDTH)
                       && y < coord_t'(ACTIVE_HEIGHT);

    always_ff @(posedge clock) begin
        if (reset) begin
            wren_q      <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            wren_q      <= in_window;
            // last pixel of the line before the start line
            frame_start <= in_window && x == coord_t'(ACTIVE_WIDTH - 1)
                           && y == coord_t'(START_LINE - 1);
        end
    end

    always_ff @(posedge clock) begin
        addr_q <= ring_addr(y, x, ACTIVE_WIDTH, BUFFER_LINES);
        data_q <= pixel;
    end

    assign wr = '{wren: wren_q, addr: addr_q, data: data_q};

endmodule

// ==== rtl/line_ram.sv ====
module line_ram #(
    parameter int ACTIVE_WIDTH = 16,
    parameter int BUFFER_LINES = 4
) (
    input  logic                     wr_clock,
    input  dc_video_pkg::ram_write_t wr,
    input  logic                     rd_clock,
    input  dc_video_pkg::ram_addr_t  rd_addr,
    output dc_video_pkg::rgb_t       rd_data
);
    import dc_video_pkg::*;

    localparam int DEPTH = ACTIVE_WIDTH * BUFFER_LINES;
    localparam int AW    = $clog2(DEPTH);

    rgb_t mem [DEPTH];

    always_ff @(posedge wr_clock) begin
        if (wr.wren) begin
            mem[wr.addr[AW-1:0]] <= wr.data;
        end
    end

    // registered read in the output domain
    always_ff @(posedge rd_clock) begin
        rd_data <= mem[rd_addr[AW-1:0]];
    end

endmodule

// ==== rtl/flag_cross_domain.sv ====
module flag_cross_domain (
    input  logic clock_a,
    input  logic reset,
    input  logic flag_a,
    input  logic clock_b,
    output logic flag_b
);

    logic       toggle_a;
    logic [2:0] sync_b;

    // each flag flips the level
    always_ff @(posedge clock_a) begin
        if (reset) begin
            toggle_a <= 1'b0;
        end else if (flag_a) begin
            toggle_a <= ~toggle_a;
        end
    end

    // third flop only keeps the previous level for edge detection
    always_ff @(posedge clock_b) begin
        if (reset) begin
            sync_b <= '0;
        end else begin
            sync_b <= {sync_b[1:0], toggle_a};
        end
    end

    assign flag_b = sync_b[2] ^ sync_b[1];

endmodule

// ==== rtl/startup_delay.sv ====
module startup_delay #(
    parameter int STARTUP_CYCLES = 20
) (
    input  logic clock,
    input  logic reset,
    output logic ready
);

    localparam int CW = $clog2(STARTUP_CYCLES + 1);

    logic [CW-1:0] count;

    // saturates at the end value
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (count != CW'(STARTUP_CYCLES)) begin
            count <= count + 1'b1;
        end
    end

    assign ready = (count == CW'(STARTUP_CYCLES));

endmodule

// ==== rtl/hdmi_timing_out.sv ====
module hdmi_timing_out #(
    parameter int ACTIVE_WIDTH  = 16,
    parameter int ACTIVE_HEIGHT = 8,
    parameter int BUFFER_LINES  = 4,
    parameter int H_TOTAL       = 64,
    parameter int H_SYNC_START  = 40,
    parameter int H_SYNC_END    = 48,
    parameter int V_TOTAL       = 10,
    parameter int V_SYNC_START  = 8,
    parameter int V_SYNC_END    = 9
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    ready,
    input  logic                    start,
    input  dc_video_pkg::rgb_t      rd_data,
    output dc_video_pkg::ram_addr_t rd_addr,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de,
    output dc_video_pkg::rgb_t      video
);
    import dc_video_pkg::*;

    logic   running;
    coord_t col;
    coord_t line;
    logic   line_end;
    logic   de_s1;
    logic   hsync_s1;
    logic   vsync_s1;

    assign line_end = (col == coord_t'(H_TOTAL - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
            col     <= '0;
            line    <= '0;
        end else if (!running) begin
            // start ignored until the startup delay is over
            if (ready && start) begin
                running <= 1'b1;
            end
        end else if (line_end) begin
            col <= '0;
            if (line == coord_t'(V_TOTAL - 1)) begin
                running <= 1'b0;
                line    <= '0;
            end else begin
                line <= line + 1'b1;
            end
        end else begin
            col <= col + 1'b1;
        end
    end

    assign rd_addr = ring_addr(line, col, ACTIVE_WIDTH, BUFFER_LINES);

    // stage 1 lines up with rd_data, stage 2 drives the pins
    always_ff @(posedge clock) begin
        if (reset) begin
            de_s1    <= 1'b0;
            hsync_s1 <= 1'b0;
            vsync_s1 <= 1'b0;
            de       <= 1'b0;
            hsync    <= 1'b0;
            vsync    <= 1'b0;
            video    <= '0;
        end else begin
            de_s1    <= running && col < coord_t'(ACTIVE_WIDTH)
                        && line < coord_t'(ACTIVE_HEIGHT);
            hsync_s1 <= running && col >= coord_t'(H_SYNC_START)
                        && col < coord_t'(H_SYNC_END);
            vsync_s1 <= running && line >= coord_t'(V_SYNC_START)
                        && line < coord_t'(V_SYNC_END);
            de       <= de_s1;
            hsync    <= hsync_s1;
            vsync    <= vsync_s1;
            video    <= de_s1 ? rd_data : '0;
        end
    end

endmodule

// ==== rtl/dc_hdmi_top.sv ====
module dc_hdmi_top #(
    parameter int ACTIVE_WIDTH   = 16,
    parameter int ACTIVE_HEIGHT  = 8,
    parameter int BUFFER_LINES   = 4,
    parameter int START_LINE     = 2,
    parameter int H_TOTAL        = 64,
    parameter int H_SYNC_START   = 40,
    parameter int H_SYNC_END     = 48,
    parameter int V_TOTAL        = 10,
    parameter int V_SYNC_START   = 8,
    parameter int V_SYNC_END     = 9,
    parameter int STARTUP_CYCLES = 20
) (
    input  logic               clock54,
    input  logic               hdmi_clock,
    input  logic               reset,
    input  logic               _hsync,
    input  logic               _vsync,
    input  logic [11:0]        data,
    output logic               hsync,
    output logic               vsync,
    output logic               de,
    output dc_video_pkg::rgb_t video
);
    import dc_video_pkg::*;

    logic       pixel_valid;
    rgb_t       pixel;
    coord_t     x;
    coord_t     y;
    ram_write_t wr;
    logic       frame_start;
    ram_addr_t  rd_addr;
    rgb_t       rd_data;
    logic       output_start;
    logic       ready;

    // input pixel domain
    dc_video_capture i_capture (
        .clock       (clock54),
        .reset       (reset),
        ._hsync      (_hsync),
        ._vsync      (_vsync),
        .data        (data),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .x           (x),
        .y           (y)
    );

    line_writer #(
        .ACTIVE_WIDTH  (ACTIVE_WIDTH),
        .ACTIVE_HEIGHT (ACTIVE_HEIGHT),
        .BUFFER_LINES  (BUFFER_LINES),
        .START_LINE    (START_LINE)
    ) i_writer (
        .clock       (clock54),
        .reset       (reset),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .x           (x),
        .y           (y),
        .wr          (wr),
        .frame_start (frame_start)
    );

    // crossing between the two domains
    line_ram #(
        .ACTIVE_WIDTH (ACTIVE_WIDTH),
        .BUFFER_LINES (BUFFER_LINES)
    ) i_ram (
        .wr_clock (clock54),
        .wr       (wr),
        .rd_clock (hdmi_clock),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    flag_cross_domain i_trigger (
        .clock_a (clock54),
        .reset   (reset),
        .flag_a  (frame_start),
        .clock_b (hdmi_clock),
        .flag_b  (output_start)
    );

    // output domain
    startup_delay #(
        .STARTUP_CYCLES (STARTUP_CYCLES)
    ) i_startup (
        .clock (hdmi_clock),
        .reset (reset),
        .ready (ready)
    );

    hdmi_timing_out #(
        .ACTIVE_WIDTH  (ACTIVE_WIDTH),
        .ACTIVE_HEIGHT (ACTIVE_HEIGHT),
        .BUFFER_LINES  (BUFFER_LINES),
        .H_TOTAL       (H_TOTAL),
        .H_SYNC_START  (H_SYNC_START),
        .H_SYNC_END    (H_SYNC_END),
        .V_TOTAL       (V_TOTAL),
        .V_SYNC_START  (V_SYNC_START),
        .V_SYNC_END    (V_SYNC_END)
    ) i_timing (
        .clock   (hdmi_clock),
        .reset   (reset),
        .ready   (ready),
        .start   (output_start),
        .rd_data (rd_data),
        .rd_addr (rd_addr),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .video   (video)
    );

endmodule

// ==== bench/dc_hdmi_props.sv ====
module dc_hdmi_props #(
    parameter int H_SYNC_LEN = 8
) (
    input logic hdmi_clock,
    input logic clock54,
    input logic reset,
    input logic ready,
    input logic frame_start,
    input logic output_start,
    input logic hsync,
    input logic vsync,
    input logic de
);
    timeunit 1ns;
    timeprecision 1ps;

    int hsync_run;
    int starts_sent;
    int starts_seen;
    int start_wait;

    always_ff @(posedge hdmi_clock) begin
        if (reset) begin
            hsync_run <= 0;
        end else if (hsync) begin
            hsync_run <= hsync_run + 1;
        end else begin
            hsync_run <= 0;
        end
    end

    always_ff @(posedge clock54) begin
        if (reset) begin
            starts_sent <= 0;
        end else if (frame_start) begin
            starts_sent <= starts_sent + 1;
        end
    end

    // cycles a crossed flag has been pending
    always_ff @(posedge hdmi_clock) begin
        if (reset) begin
            starts_seen <= 0;
            start_wait  <= 0;
        end else begin
            if (output_start) begin
                starts_seen <= starts_seen + 1;
            end
            if (starts_sent > starts_seen && !output_start) begin
                start_wait <= start_wait + 1;
            end else begin
                start_wait <= 0;
            end
        end
    end

    a_hsync_length: assert property (@(posedge hdmi_clock) disable iff (reset)
        $fell(hsync) |-> hsync_run == H_SYNC_LEN)
        else $error("hsync pulse ended after %0d cycles", hsync_run);

    a_hsync_max: assert property (@(posedge hdmi_clock) disable iff (reset)
        hsync |-> hsync_run < H_SYNC_LEN)
        else $error("hsync pulse longer than the sync window");

    a_de_no_sync: assert property (@(posedge hdmi_clock) disable iff (reset)
        de |-> !hsync && !vsync)
        else $error("de high together with a sync pulse");

    a_idle_outputs: assert property (@(posedge hdmi_clock)
        (reset || !ready) |=> !de && !hsync && !vsync)
        else $error("output active during reset or before ready");

    a_start_single: assert property (@(posedge hdmi_clock) disable iff (reset)
        output_start |-> starts_seen < starts_sent)
        else $error("output_start without a matching frame_start");

    a_start_pulse: assert property (@(posedge hdmi_clock) disable iff (reset)
        output_start |=> !output_start)
        else $error("output_start longer than one cycle");

    a_start_latency: assert property (@(posedge hdmi_clock) disable iff (reset)
        start_wait < 3)
        else $error("frame_start not crossed within 3 hdmi_clock cycles");

endmodule

// ==== bench/dc_hdmi_tb.sv ====
module dc_hdmi_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import dc_video_pkg::*;

    localparam int ACTIVE_WIDTH  = 16;
    localparam int ACTIVE_HEIGHT = 8;
    localparam int FRAME_PIXELS  = ACTIVE_WIDTH * ACTIVE_HEIGHT;
    localparam int NUM_FRAMES    = 4;
    localparam int SYNC_PIXELS   = 4;
    localparam int LINE_PIXELS   = 24;
    localparam int BLANK_LINES   = 3;
    localparam int FRAME_LINES   = 1 + ACTIVE_HEIGHT + BLANK_LINES;
    localparam int CLOCK54_NS    = 40;
    // two clock54 cycles per pixel
    localparam int FRAME_NS      = FRAME_LINES * LINE_PIXELS * 2 * CLOCK54_NS;
    localparam int WATCHDOG_NS   = 5 * FRAME_NS;

    logic        clock54 = 1'b0;
    logic        hdmi_clock = 1'b0;
    logic        reset;
    logic        _hsync;
    logic        _vsync;
    logic [11:0] data;
    logic        hsync;
    logic        vsync;
    logic        de;
    rgb_t        video;

    logic [31:0] lcg_state = 32'hec91;
    rgb_t        expected_q[$];
    rgb_t        expected_pixel;
    int          de_count = 0;
    int          frames_checked = 0;
    logic        vsync_prev = 1'b0;

    always #(CLOCK54_NS / 2) clock54 = ~clock54;
    // 64 output cycles span one 24-pixel input line
    always #15 hdmi_clock = ~hdmi_clock;

    dc_hdmi_top i_dut (
        .clock54    (clock54),
        .hdmi_clock (hdmi_clock),
        .reset      (reset),
        ._hsync     (_hsync),
        ._vsync     (_vsync),
        .data       (data),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de),
        .video      (video)
    );

    bind dc_hdmi_top dc_hdmi_props #(
        .H_SYNC_LEN (H_SYNC_END - H_SYNC_START)
    ) i_props (
        .hdmi_clock   (hdmi_clock),
        .clock54      (clock54),
        .reset        (reset),
        .ready        (ready),
        .frame_start  (frame_start),
        .output_start (output_start),
        .hsync        (hsync),
        .vsync        (vsync),
        .de           (de)
    );

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // sync pulse, active pixels, blank pixels
    task automatic drive_line(input logic vsync_level, input logic active_line);
        rgb_t p;
        int   slot;
        for (slot = 0; slot < LINE_PIXELS; slot++) begin
            p = '0;
            if (active_line && slot >= SYNC_PIXELS && slot < SYNC_PIXELS + ACTIVE_WIDTH) begin
                lcg_state = next_random(lcg_state);
                p = lcg_state[31:8];
                expected_q.push_back(p);
            end
            @(negedge clock54);
            _hsync = (slot >= SYNC_PIXELS);
            _vsync = vsync_level;
            data   = {p.red, p.green[7:4]};
            @(negedge clock54);
            data   = {p.green[3:0], p.blue};
        end
    endtask

    task automatic drive_frame();
        drive_line(1'b0, 1'b0);
        repeat (ACTIVE_HEIGHT) drive_line(1'b1, 1'b1);
        repeat (BLANK_LINES) drive_line(1'b1, 1'b0);
    endtask

    // output scoreboard sampled away from the output edge
    always @(negedge hdmi_clock) begin
        if (!reset) begin
            if (de) begin
                if (expected_q.size() == 0) begin
                    stop_with_failure("de went high with no input pixel left to compare");
                end else begin
                    expected_pixel = expected_q.pop_front();
                    assert (video == expected_pixel) else begin
                        stop_with_failure($sformatf(
                            "[ERROR] frame_pixels frame %0d pixel %0d: expected %h, actual %h",
                            frames_checked, de_count, expected_pixel, video));
                    end
                end
                de_count++;
            end else begin
                // blanked pixel outside the active window
                assert (video == 24'h000000) else begin
                    stop_with_failure($sformatf(
                        "[ERROR] blank_video frame %0d: expected %h, actual %h",
                        frames_checked, 24'h000000, video));
                end
            end
            if (vsync && !vsync_prev) begin
                assert (de_count == FRAME_PIXELS) else begin
                    stop_with_failure($sformatf(
                        "[ERROR] frame_size frame %0d: expected %0d, actual %0d",
                        frames_checked, FRAME_PIXELS, de_count));
                end
                de_count = 0;
                frames_checked++;
            end
            vsync_prev = vsync;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("watchdog expired before all output frames were checked");
    end

    initial begin
        reset  = 1'b1;
        _hsync = 1'b1;
        _vsync = 1'b1;
        data   = '0;
        repeat (10) @(negedge clock54);
        reset = 1'b0;
        repeat (NUM_FRAMES) drive_frame();
        wait (frames_checked == NUM_FRAMES);
        if (expected_q.size() != 0) begin
            stop_with_failure("input pixels were left over after the last output frame");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== dc_hdmi.f ====
rtl/dc_video_pkg.sv
rtl/dc_video_capture.sv
rtl/line_writer.sv
rtl/line_ram.sv
rtl/flag_cross_domain.sv
rtl/startup_delay.sv
rtl/hdmi_timing_out.sv
rtl/dc_hdmi_top.sv
bench/dc_hdmi_props.sv
bench/dc_hdmi_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator; exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dc_hdmi_tb -f dc_hdmi.f -o dc_hdmi_sim \
    && ./obj_dir/dc_hdmi_sim \
    || { echo "simulation failed"; exit 1; }
